// ==== Makefile ====
# Verilator build and run for the x68 glue testbench

VERILATOR := verilator
TOP       := x68_glue_tb
FILELIST  := x68_glue.f
FLAGS     := --binary --timing --assert -Wno-fatal
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
PASS_TEXT := No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulation prints the pass text
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/x68_glue_tb.sv ====
// X68 glue testbench
// Checks the clock enables, the loader handshake, the disk LED
// and the audio path against models of their rules
`timescale 1ns/1ps
`default_nettype none

module x68_glue_tb import x68_glue_pkg::*; ();

	logic clk_sys = 1'b0;
	logic rst;
	logic turbo_req;
	logic snd_mode;
	logic comp_mode;
	logic ioctl_download;
	logic ioctl_wr;
	logic core_ack;
	logic disk_access;
	logic [15:0] core_l;
	logic [15:0] core_r;
	logic [15:0] synth_l;
	logic [15:0] synth_r;
	logic sys_ce;
	logic mpu_cep;
	logic mpu_cen;
	logic snd_ce;
	logic [1:0] opn_ce;
	logic core_wr;
	logic core_run;
	logic disk_led;
	logic [15:0] audio_l;
	logic [15:0] audio_r;

	// Audio stimulus with one entry per cycle
	logic [15:0] q_cl[$];
	logic [15:0] q_cr[$];
	logic [15:0] q_sl[$];
	logic [15:0] q_sr[$];
	logic q_mode[$];
	logic [31:0] rng = 32'hd05e855c;
	int n;

	x68_glue DUT (.*);

	always #20 clk_sys = ~clk_sys;

	////////////////////
	// Reporting
	////////////////////

	task automatic report_error(input string msg);
		$display("Errors found");
		$display("%s", msg);
		$fatal(1);
	endtask

	task automatic check_hex(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (expected == actual)
		else report_error($sformatf("error %s expected %h actual %h",
			name, expected, actual));
	endtask

	// CPU phases are exclusive in both modes
	phase_excl: assert property (@(posedge clk_sys) disable iff (rst) !(mpu_cep && mpu_cen))
		else report_error("mpu_cep and mpu_cen were high in the same cycle");
	// System enable is a single cycle pulse
	sys_single: assert property (@(posedge clk_sys) disable iff (rst) !(sys_ce && $past(sys_ce)))
		else report_error("sys_ce stayed high for more than one cycle");

	////////////////////
	// Helpers
	////////////////////

	function automatic logic read_output(input string name);
		case (name)
			"sys_ce": return sys_ce;
			"mpu_cep": return mpu_cep;
			"mpu_cen": return mpu_cen;
			"snd_ce": return snd_ce;
			"opn_ce0": return opn_ce[0];
			"opn_ce1": return opn_ce[1];
			"core_wr": return core_wr;
			"core_run": return core_run;
			default: return disk_led;
		endcase
	endfunction

	// Falling edges counted until the output reaches the level
	task automatic wait_level(input string name, input logic level, input int limit,
		output int cycles);
		cycles = 0;
		forever begin
			@(negedge clk_sys);
			cycles++;
			if (read_output(name) == level)
				break;
			if (cycles >= limit)
				report_error($sformatf("timeout after %0d cycles waiting for %s", cycles, name));
		end
	endtask

	// Two full periods measured after the first pulse
	task automatic check_period(input string name, input int period);
		int gap;
		wait_level(name, 1'b1, 2 * period + 2, gap);
		repeat (2) begin
			wait_level(name, 1'b1, period + 2, gap);
			check_hex({name, " period"}, period, gap);
		end
	endtask

	task automatic pulse_write();
		@(posedge clk_sys);
		ioctl_wr <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
	endtask

	task automatic pulse_access();
		@(posedge clk_sys);
		disk_access <= 1'b1;
		@(posedge clk_sys);
		disk_access <= 1'b0;
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	////////////////////
	// Audio model
	////////////////////

	// Signed sum clamped to 16 bits
	function automatic logic [15:0] mix_model(input logic [15:0] a, input logic [15:0] b);
		int s;
		s = int'($signed(a)) + int'($signed(b));
		if (s > 32767)
			s = 32767;
		else if (s < -32768)
			s = -32768;
		return s[15:0];
	endfunction

	// Gain below the knee and a shallow slope above, then the sign put back
	function automatic logic [15:0] compress_model(input logic [15:0] smp, input logic mode);
		int mag;
		int res;
		mag = int'($signed(smp));
		if (mag < 0)
			mag = -mag;
		if (mode == 1'b0)
			res = (mag < 14044) ? mag * 2 : (mag - 14044) / 4 + 28088;
		else
			res = (mag < 7399) ? mag * 4 : (mag - 7399) / 8 + 29596;
		if (smp[15])
			res = -res;
		return res[15:0];
	endfunction

	task automatic add_sample(input logic [15:0] cl, input logic [15:0] cr,
		input logic [15:0] sl, input logic [15:0] sr, input logic mode);
		q_cl.push_back(cl);
		q_cr.push_back(cr);
		q_sl.push_back(sl);
		q_sr.push_back(sr);
		q_mode.push_back(mode);
	endtask

	// One sample per cycle with each result checked two cycles later
	task automatic run_audio();
		logic [15:0] exp_l[$];
		logic [15:0] exp_r[$];
		int total;
		total = q_cl.size();
		for (int i = 0; i < total + 2; i++) begin
			@(posedge clk_sys);
			if (i < total) begin
				core_l <= q_cl[i];
				core_r <= q_cr[i];
				synth_l <= q_sl[i];
				synth_r <= q_sr[i];
				comp_mode <= q_mode[i];
				exp_l.push_back(compress_model(mix_model(q_cl[i], q_sl[i]), q_mode[i]));
				exp_r.push_back(compress_model(mix_model(q_cr[i], q_sr[i]), q_mode[i]));
			end
			@(negedge clk_sys);
			if (i >= 2) begin
				check_hex("audio_l", exp_l.pop_front(), audio_l);
				check_hex("audio_r", exp_r.pop_front(), audio_r);
			end
		end
	endtask

	////////////////////
	// Stimulus
	////////////////////

	initial begin
		logic prev;
		logic [31:0] r1;
		rst <= 1'b1;
		turbo_req <= 1'b0;
		snd_mode <= 1'b0;
		comp_mode <= 1'b0;
		ioctl_download <= 1'b0;
		ioctl_wr <= 1'b0;
		core_ack <= 1'b0;
		disk_access <= 1'b0;
		core_l <= '0;
		core_r <= '0;
		synth_l <= '0;
		synth_r <= '0;
		repeat (3) @(posedge clk_sys);
		rst <= 1'b0;

		// Everything idle straight out of reset
		@(negedge clk_sys);
		check_hex("sys_ce", 0, sys_ce);
		check_hex("mpu_cep", 0, mpu_cep);
		check_hex("mpu_cen", 0, mpu_cen);
		check_hex("snd_ce", 0, snd_ce);
		check_hex("opn_ce", 0, opn_ce);
		check_hex("core_wr", 0, core_wr);
		check_hex("core_run", 0, core_run);
		check_hex("disk_led", 0, disk_led);
		check_hex("audio_l", 0, audio_l);
		check_hex("audio_r", 0, audio_r);

		// Normal mode periods
		check_period("sys_ce", 4);
		check_period("opn_ce0", 10);
		check_period("opn_ce1", 20);
		check_period("snd_ce", 5);
		check_period("mpu_cep", 4);
		check_period("mpu_cen", 4);
		// cen trails cep by two cycles
		wait_level("mpu_cep", 1'b1, 6, n);
		wait_level("mpu_cen", 1'b1, 6, n);
		check_hex("mpu_cen delay", 2, n);

		// Slow sound clock after the counters settle
		@(posedge clk_sys);
		snd_mode <= 1'b1;
		repeat (25) @(posedge clk_sys);
		check_period("snd_ce", 10);

		// Turbo takes effect after the next system boundary
		@(posedge clk_sys);
		turbo_req <= 1'b1;
		@(negedge clk_sys);
		wait_level("sys_ce", 1'b1, 6, n);
		prev = mpu_cep;
		repeat (12) begin
			@(negedge clk_sys);
			check_hex("mpu_cep", !prev, mpu_cep);
			check_hex("mpu_cen", prev, mpu_cen);
			prev = mpu_cep;
		end

		// Loader handshake during a download
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		wait_level("core_run", 1'b1, 4, n);
		repeat (3) begin
			pulse_write();
			wait_level("core_wr", 1'b1, 2, n);
			// Request holds while the core has not answered
			repeat (4) begin
				@(negedge clk_sys);
				check_hex("core_wr", 1, core_wr);
			end
			@(posedge clk_sys);
			core_ack <= 1'b1;
			wait_level("core_wr", 1'b0, 2, n);
			@(posedge clk_sys);
			core_ack <= 1'b0;
		end
		// Writes after the download are ignored
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		repeat (3) begin
			pulse_write();
			repeat (4) begin
				@(negedge clk_sys);
				check_hex("core_wr", 0, core_wr);
			end
		end
		check_hex("core_run", 1, core_run);

		// LED retriggered twice and then left to expire
		pulse_access();
		wait_level("disk_led", 1'b1, 2, n);
		repeat (2) begin
			repeat (1000) @(negedge clk_sys);
			check_hex("disk_led", 1, disk_led);
			pulse_access();
		end
		wait_level("disk_led", 1'b0, led_hold_cycles + 10, n);
		assert (n >= led_hold_cycles && n <= led_hold_cycles + 2)
		else report_error($sformatf("error disk_led hold expected %h actual %h",
			led_hold_cycles, n));

		// Limits and knees in both curves followed by random samples
		for (int m = 0; m < 2; m++) begin
			add_sample(16'h7fff, 16'h8000, 16'h7fff, 16'h8000, m[0]);
			add_sample(16'h7fff, 16'h8000, 16'h0001, 16'hffff, m[0]);
			add_sample(16'h4000, 16'hc000, 16'h3fff, 16'hc001, m[0]);
			add_sample(16'h0000, 16'h0000, 16'h0000, 16'h0000, m[0]);
			add_sample(16'd14044, 16'h0000 - 16'd14044, 16'h0000, 16'h0000, m[0]);
			add_sample(16'd14043, 16'h0000 - 16'd14043, 16'h0000, 16'h0000, m[0]);
			add_sample(16'd7399, 16'h0000 - 16'd7399, 16'h0000, 16'h0000, m[0]);
			add_sample(16'd7398, 16'h0000 - 16'd7398, 16'h0000, 16'h0000, m[0]);
		end
		repeat (200) begin
			rng = xorshift(rng);
			r1 = rng;
			rng = xorshift(rng);
			add_sample(r1[15:0], r1[31:16], rng[15:0], rng[31:16], rng[7]);
		end
		run_audio();

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/activity_led.sv ====
// Disk activity LED
// Retriggerable stretcher, holds the LED on for a fixed
// time after the last access pulse
`timescale 1ns/1ps
`default_nettype none

module activity_led import x68_glue_pkg::*; (
	input  wire  clk_sys,
	input  wire  rst,
	input  wire  disk_access,
	output logic disk_led
);

	// Remaining hold time
	logic [$bits(led_hold_cycles)-1:0] hold_cnt;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			hold_cnt <= '0;
		end else if (disk_access) begin
			// Each pulse restarts the window
			hold_cnt <= led_hold_cycles;
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
	end

	// On while time is left
	assign disk_led = (hold_cnt != '0);

endmodule

`default_nettype wire

// ==== logic/audio_compressor.sv ====
// Audio mixer and compressor
// Two stage stereo pipeline, a saturating add of core and synth
// audio, then a two curve dynamic range compressor
`timescale 1ns/1ps
`default_nettype none

module audio_compressor import x68_glue_pkg::*; (
	input  wire                clk_sys,
	input  wire                rst,
	input  wire                comp_mode,
	input  wire  [audio_w-1:0] core_l,
	input  wire  [audio_w-1:0] core_r,
	input  wire  [audio_w-1:0] synth_l,
	input  wire  [audio_w-1:0] synth_r,
	output logic [audio_w-1:0] audio_l,
	output logic [audio_w-1:0] audio_r
);

	// Saturated sums, stage 1
	logic [audio_w-1:0] sat_l;
	logic [audio_w-1:0] sat_r;
	// Curve select travels with the sample
	logic mode_d;

	////////////////////
	// Helpers
	////////////////////

	// Signed add with clamp to the 16 bit range
	function automatic logic [audio_w-1:0] sat_add(input logic [audio_w-1:0] a,
		input logic [audio_w-1:0] b);
		logic [audio_w:0] sum;
		sum = {a[audio_w-1], a} + {b[audio_w-1], b};
		// Top two bits differ on overflow
		if (sum[audio_w] ^ sum[audio_w-1])
			sat_add = {sum[audio_w], {(audio_w-1){~sum[audio_w]}}};
		else
			sat_add = sum[audio_w-1:0];
	endfunction

	// Magnitude through the chosen curve, sign put back after
	function automatic logic [audio_w-1:0] compr(input logic [audio_w-1:0] smp,
		input logic mode);
		logic [audio_w-1:0] mag;
		logic [audio_w-1:0] v1;
		logic [audio_w-1:0] v2;
		logic [audio_w-1:0] v;
		mag = smp[audio_w-1] ? (~smp + 1'b1) : smp;
		// Linear gain below the knee, shallow slope above
		v1 = (mag < comp_x1) ? (mag * comp_a1) : (((mag - comp_x1) / comp_f1) + comp_b1);
		v2 = (mag < comp_x2) ? (mag * comp_a2) : (((mag - comp_x2) / comp_f2) + comp_b2);
		v = mode ? v2 : v1;
		compr = smp[audio_w-1] ? (~v + 1'b1) : v;
	endfunction

	////////////////////
	// Pipeline
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			sat_l <= '0;
			sat_r <= '0;
			mode_d <= 1'b0;
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			// Stage 1, mix
			sat_l <= sat_add(core_l, synth_l);
			sat_r <= sat_add(core_r, synth_r);
			mode_d <= comp_mode;
			// Stage 2, compress
			audio_l <= compr(sat_l, mode_d);
			audio_r <= compr(sat_r, mode_d);
		end
	end

endmodule

`default_nettype wire

// ==== logic/ce_gen.sv ====
// Clock enable generator
// Free running dividers on clk_sys give the system, CPU phase,
// sound and FM synth enables, with a turbo CPU mode
`timescale 1ns/1ps
`default_nettype none

module ce_gen import x68_glue_pkg::*; (
	input  wire       clk_sys,
	input  wire       rst,
	input  wire       turbo_req,
	input  wire       snd_mode,
	output logic      sys_ce,
	output logic      mpu_cep,
	output logic      mpu_cen,
	output logic      snd_ce,
	output logic [1:0] opn_ce
);

	logic [sys_div_bits-1:0] div_sys;
	logic [3:0] div_snd;
	logic [3:0] div_snd2;
	logic [4:0] div_opn;
	logic turbo;

	// Terminal counts of each divider
	logic sys_last;
	logic snd_fast_last;
	logic snd_slow_last;
	logic opn_last;
	// Normal mode cen point, two cycles before the system boundary
	logic sys_half;

	assign sys_last      = &div_sys;
	assign sys_half      = ~div_sys[sys_div_bits-1] & (&div_sys[sys_div_bits-2:0]);
	assign snd_fast_last = (div_snd == snd_fast_div - 4'd1);
	assign snd_slow_last = (div_snd2 == snd_slow_div - 4'd1);
	assign opn_last      = (div_opn == opn_div - 5'd1);

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			div_sys <= '0;
			div_snd <= '0;
			div_snd2 <= '0;
			div_opn <= '0;
			turbo <= 1'b0;
			sys_ce <= 1'b0;
			mpu_cep <= 1'b0;
			mpu_cen <= 1'b0;
			snd_ce <= 1'b0;
			opn_ce <= 2'b00;
		end else begin
			// System divider wraps on its own
			div_sys <= div_sys + 1'b1;
			div_snd <= snd_fast_last ? 4'd0 : div_snd + 4'd1;
			div_snd2 <= snd_slow_last ? 4'd0 : div_snd2 + 4'd1;
			div_opn <= opn_last ? 5'd0 : div_opn + 5'd1;

			sys_ce <= sys_last;

			// Mode change only at the boundary so phases never glitch
			if (sys_last)
				turbo <= turbo_req;

			// Turbo toggles phases every cycle
			mpu_cep <= turbo ? div_sys[0] : sys_last;
			mpu_cen <= turbo ? ~div_sys[0] : sys_half;

			snd_ce <= snd_mode ? snd_slow_last : snd_fast_last;
			opn_ce <= {opn_last, snd_slow_last};
		end
	end

endmodule

`default_nettype wire

// ==== logic/loader_bridge.sv ====
// ROM loader bridge
// Turns host download writes into a write/ack handshake toward
// the core and releases the core once a download has begun
`timescale 1ns/1ps
`default_nettype none

module loader_bridge import x68_glue_pkg::*; (
	input  wire  clk_sys,
	input  wire  rst,
	input  wire  ioctl_download,
	input  wire  ioctl_wr,
	input  wire  core_ack,
	output logic core_wr,
	output logic core_run
);

	// Previous values for edge detection
	logic old_download;
	logic old_ack;
	// Download has ended, no more requests
	logic done;

	logic ack_rise;
	logic dl_rise;
	logic dl_fall;

	assign ack_rise = ~old_ack & core_ack;
	assign dl_rise  = ~old_download & ioctl_download;
	assign dl_fall  = old_download & ~ioctl_download;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			old_download <= 1'b0;
			old_ack <= 1'b0;
			core_wr <= 1'b0;
			done <= 1'b0;
			core_run <= 1'b0;
		end else begin
			old_download <= ioctl_download;
			old_ack <= core_ack;

			// Request completes on the ack edge
			if (ack_rise & core_wr)
				core_wr <= 1'b0;
			// New host write wins over completion
			if (ioctl_wr & ~done)
				core_wr <= 1'b1;

			if (dl_fall)
				done <= 1'b1;
			// Core leaves reset at download start
			if (dl_rise)
				core_run <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== logic/x68_glue.sv ====
// X68 glue top level
// Clock enables, ROM loader handshake, disk LED and audio
// path between the host interface and the computer core
`timescale 1ns/1ps
`default_nettype none

module x68_glue (
	input  wire        clk_sys,
	input  wire        rst,

	// CPU speed and sound clock selection
	input  wire        turbo_req,
	input  wire        snd_mode,

	// Host download and core loader
	input  wire        ioctl_download,
	input  wire        ioctl_wr,
	input  wire        core_ack,

	// Disk access pulse from the core
	input  wire        disk_access,

	// Audio sources and compressor curve
	input  wire [15:0] core_l,
	input  wire [15:0] core_r,
	input  wire [15:0] synth_l,
	input  wire [15:0] synth_r,
	input  wire        comp_mode,

	output wire        sys_ce,
	output wire        mpu_cep,
	output wire        mpu_cen,
	output wire        snd_ce,
	output wire [1:0]  opn_ce,

	// core_wr doubles as the host wait signal
	output wire        core_wr,
	output wire        core_run,

	output wire        disk_led,

	output wire [15:0] audio_l,
	output wire [15:0] audio_r
);

	////////////////////
	// Clock enables
	////////////////////

	ce_gen u_ce_gen (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.turbo_req (turbo_req),
		.snd_mode  (snd_mode),
		.sys_ce    (sys_ce),
		.mpu_cep   (mpu_cep),
		.mpu_cen   (mpu_cen),
		.snd_ce    (snd_ce),
		.opn_ce    (opn_ce)
	);

	////////////////////
	// Loader and LED
	////////////////////

	loader_bridge u_loader_bridge (
		.clk_sys        (clk_sys),
		.rst            (rst),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.core_ack       (core_ack),
		.core_wr        (core_wr),
		.core_run       (core_run)
	);

	activity_led u_activity_led (
		.clk_sys     (clk_sys),
		.rst         (rst),
		.disk_access (disk_access),
		.disk_led    (disk_led)
	);

	////////////////////
	// Audio
	////////////////////

	audio_compressor u_audio_compressor (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.comp_mode (comp_mode),
		.core_l    (core_l),
		.core_r    (core_r),
		.synth_l   (synth_l),
		.synth_r   (synth_r),
		.audio_l   (audio_l),
		.audio_r   (audio_r)
	);

endmodule

`default_nettype wire

// ==== logic/x68_glue_pkg.sv ====
// X68 glue shared constants
// Divider counts for the clock enables, disk LED hold time,
// audio sample width and the two compressor curves
`default_nettype none

package x68_glue_pkg;

	////////////////////
	// Clock enables
	////////////////////

	// System divider width, enable every 4 cycles
	localparam int sys_div_bits = 2;

	// Fast sound period
	localparam logic [3:0] snd_fast_div = 4'd5;
	// Slow sound period, also FM enable bit 0
	localparam logic [3:0] snd_slow_div = 4'd10;
	// FM enable bit 1 period
	localparam logic [4:0] opn_div = 5'd20;

	////////////////////
	// Disk LED
	////////////////////

	// Hold time after the last access pulse
	localparam logic [22:0] led_hold_cycles = 23'd4500000;

	////////////////////
	// Audio
	////////////////////

	localparam int audio_w = 16;

	// Curve 1, gentle
	// Slope divisor above the knee and gain below it
	localparam logic [3:0] comp_f1 = 4'd4;
	localparam logic [3:0] comp_a1 = 4'd2;
	// Knee input and output at the knee
	localparam logic [15:0] comp_x1 = 16'd14044;
	localparam logic [15:0] comp_b1 = 16'd28088;

	// Curve 2, stronger
	localparam logic [3:0] comp_f2 = 4'd8;
	localparam logic [3:0] comp_a2 = 4'd4;
	localparam logic [15:0] comp_x2 = 16'd7399;
	localparam logic [15:0] comp_b2 = 16'd29596;

endpackage

`default_nettype wire

// ==== x68_glue.f ====
logic/x68_glue_pkg.sv
logic/ce_gen.sv
logic/loader_bridge.sv
logic/activity_led.sv
logic/audio_compressor.sv
logic/x68_glue.sv
bench/x68_glue_tb.sv
